// File: verilog.f
+incdir+verilog
verilog/dma_op_pkg.sv
verilog/dma_word_pkg.sv
verilog/dma_op_sequencer.sv
verilog/dma_status_regs.sv
verilog/dma_word_counter.sv
verilog/dma_rx_fifo.sv
verilog/dma_bus_master.sv
tests/tb_dma_bus_master.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the DMA bus master testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f verilog.f \
   --top-module tb_dma_bus_master -Mdir obj_dir -o sim_tb \
   && ./obj_dir/sim_tb | grep -F "Everything OK" \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }

// File: tests/tb_dma_bus_master.sv
// ==========================================================================
// DMA bus master testbench
// Directed tests with a network-side op-code model, receive buffer
// drain checks and a cycle watchdog
// ==========================================================================
`timescale 1ns/1ps
`include "dma_settings.svh"

module tb_dma_bus_master;
   import dma_op_pkg::*;
   import dma_word_pkg::*;

   // Byte lengths of the transfers, in test order
   localparam int XFER_LENS [5] = '{13, 0, 4, 5, 2047};

   logic        nclk;
   logic        nreset;
   logic        dma_rd_request;
   queue_id_t   dma_rd_request_q;
   rx_word_t    dma_rd_data;
   logic        dma_rd_en;
   logic        dma_empty;
   logic        dma_nearly_empty;
   logic        dma_all_in_buf;
   logic        overflow;
   queue_vec_t  dma_pkt_avail;
   queue_vec_t  dma_can_wr_pkt;
   op_req_t     cpci_dma_op_req;
   op_code_t    cpci_dma_op_code_ack;
   logic        cpci_dma_vld_n2c;
   n2c_word_t   cpci_dma_data_n2c;
   logic        cpci_dma_q_nearly_full_c2n;

   rx_word_t    lcg_state;
   rx_word_t    sent_words [$];
   dma_status_t status_exp;
   op_code_t    ack_pipe [2];

   dma_bus_master dut0 (
      .nclk                       (nclk),
      .nreset                     (nreset),
      .dma_rd_request             (dma_rd_request),
      .dma_rd_request_q           (dma_rd_request_q),
      .dma_rd_data                (dma_rd_data),
      .dma_rd_en                  (dma_rd_en),
      .dma_empty                  (dma_empty),
      .dma_nearly_empty           (dma_nearly_empty),
      .dma_all_in_buf             (dma_all_in_buf),
      .overflow                   (overflow),
      .dma_pkt_avail              (dma_pkt_avail),
      .dma_can_wr_pkt             (dma_can_wr_pkt),
      .cpci_dma_op_req            (cpci_dma_op_req),
      .cpci_dma_op_code_ack       (cpci_dma_op_code_ack),
      .cpci_dma_vld_n2c           (cpci_dma_vld_n2c),
      .cpci_dma_data_n2c          (cpci_dma_data_n2c),
      .cpci_dma_q_nearly_full_c2n (cpci_dma_q_nearly_full_c2n)
   );

   // 100 ns period
   always #50 nclk = ~nclk;

   // ======================================================================
   // Helpers
   // ======================================================================
   function automatic rx_word_t lcg_next(rx_word_t s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Data words of a packet, byte count rounded up to whole words
   function automatic int data_words(int byte_len);
      return (byte_len + 3) / 4;
   endfunction

   // Send plus drain cycles over all transfers
   function automatic int expected_cycles();
      int total;
      int i;
      total = 0;
      for (i = 0; i < 5; i++) begin
         total += 3 * (1 + data_words(XFER_LENS[i]));
      end
      return total;
   endfunction

   function automatic dma_status_t current_status();
      dma_status_t s;
      s.pkt_avail  = dma_pkt_avail;
      s.can_wr_pkt = dma_can_wr_pkt;
      return s;
   endfunction

   task automatic abort_run();
      $display("Something failed");
      $fatal(1);
   endtask

   task automatic report_failure(string what);
      $display("%s", what);
      abort_run();
   endtask

   task automatic check_status(string name, dma_status_t got, dma_status_t exp);
      if (got !== exp) begin
         $display("[ERROR] %s: expected 0x%08h, got 0x%08h", name, exp, got);
         abort_run();
      end
   endtask

   task automatic check_word(string name, rx_word_t got, rx_word_t exp);
      if (got !== exp) begin
         $display("[ERROR] %s: expected 0x%08h, got 0x%08h", name, exp, got);
         abort_run();
      end
   endtask

   task automatic check_op_req(string name, op_req_t got, op_req_t exp);
      if (got !== exp) begin
         $display("[ERROR] %s: expected 0x%02h, got 0x%02h", name, exp, got);
         abort_run();
      end
   endtask

   task automatic check_bit(string name, logic got, logic exp);
      if (got !== exp) begin
         $display("[ERROR] %s: expected 0x%0h, got 0x%0h", name, exp, got);
         abort_run();
      end
   endtask

   // ======================================================================
   // Network-side model
   // ======================================================================
   // Echo of the requested op code, three cycles late
   task automatic echo_op_codes();
      forever begin
         @(posedge nclk);
         cpci_dma_op_code_ack <= ack_pipe[1];
         ack_pipe[1] = ack_pipe[0];
         ack_pipe[0] = cpci_dma_op_req.op_code;
      end
   endtask

   task automatic wait_for_ack(op_code_t code);
      while (cpci_dma_op_code_ack != code) begin
         @(posedge nclk);
      end
   endtask

   // One link word, all_in_buf must stay low while words still come in
   task automatic send_word(rx_word_t w);
      @(posedge nclk);
      cpci_dma_vld_n2c  <= 1'b1;
      cpci_dma_data_n2c <= w;
      sent_words.push_back(w);
      @(negedge nclk);
      check_bit("dma_all_in_buf", dma_all_in_buf, 1'b0);
   endtask

   // Request a queue, then send its length word and data
   task automatic run_transfer(queue_id_t q, int byte_len);
      int      i;
      op_req_t req_exp;
      // Back in the query loop first, so no stale transfer ack remains
      wait_for_ack(OP_STATUS_QUERY);
      @(posedge nclk);
      dma_rd_request   <= 1'b1;
      dma_rd_request_q <= q;
      @(posedge nclk);
      dma_rd_request   <= 1'b0;
      while (cpci_dma_op_req.op_code != OP_XFER_N2C) begin
         @(posedge nclk);
      end
      @(negedge nclk);
      req_exp.op_code  = OP_XFER_N2C;
      req_exp.queue_id = q;
      check_op_req("cpci_dma_op_req", cpci_dma_op_req, req_exp);
      status_exp.pkt_avail = '0;
      check_status("dma_status", current_status(), status_exp);
      wait_for_ack(OP_XFER_N2C);
      send_word(rx_word_t'(byte_len));
      for (i = 0; i < data_words(byte_len); i++) begin
         lcg_state = lcg_next(lcg_state);
         send_word(lcg_state);
      end
      @(posedge nclk);
      cpci_dma_vld_n2c <= 1'b0;
      @(negedge nclk);
      check_bit("dma_all_in_buf", dma_all_in_buf, 1'b0);
      // Rise follows the last data word by one cycle
      @(negedge nclk);
      check_bit("dma_all_in_buf", dma_all_in_buf, 1'b1);
   endtask

   // Read n words one by one and compare with what was sent
   task automatic drain_and_compare(int n);
      int       k;
      rx_word_t exp_word;
      for (k = 0; k < n; k++) begin
         @(negedge nclk);
         exp_word = sent_words.pop_front();
         check_bit("dma_empty", dma_empty, 1'b0);
         check_bit("dma_nearly_empty", dma_nearly_empty,
                   (n - k) <= `DMA_RX_NEARLY_EMPTY_LEVEL);
         check_word("dma_rd_data", dma_rd_data, exp_word);
         @(posedge nclk);
         dma_rd_en <= 1'b1;
         @(posedge nclk);
         dma_rd_en <= 1'b0;
      end
      @(negedge nclk);
      check_bit("dma_empty", dma_empty, 1'b1);
      check_bit("dma_nearly_empty", dma_nearly_empty, 1'b1);
      // Dropped words never reach the host
      sent_words.delete();
   endtask

   // ======================================================================
   // Tests
   // ======================================================================
   task automatic test_reset_values();
      op_req_t req_exp;
      req_exp.op_code  = OP_STATUS_QUERY;
      req_exp.queue_id = '0;
      @(negedge nclk);
      check_op_req("cpci_dma_op_req", cpci_dma_op_req, req_exp);
      check_status("dma_status", current_status(), '0);
      check_bit("dma_empty", dma_empty, 1'b1);
      check_bit("overflow", overflow, 1'b0);
      check_bit("cpci_dma_q_nearly_full_c2n", cpci_dma_q_nearly_full_c2n, 1'b0);
      check_bit("dma_all_in_buf", dma_all_in_buf, 1'b0);
   endtask

   task automatic test_status_query();
      dma_status_t st;
      // Queue 5 available, so the later clear is visible
      st.pkt_avail  = 16'h8421;
      st.can_wr_pkt = 16'h3c5a;
      wait_for_ack(OP_STATUS_QUERY);
      @(posedge nclk);
      cpci_dma_vld_n2c         <= 1'b1;
      cpci_dma_data_n2c.status <= st;
      @(posedge nclk);
      cpci_dma_vld_n2c <= 1'b0;
      @(negedge nclk);
      check_status("dma_status", current_status(), status_exp);
      @(negedge nclk);
      status_exp = st;
      check_status("dma_status", current_status(), status_exp);
   endtask

   task automatic test_transfer();
      run_transfer(4'd5, XFER_LENS[0]);
      drain_and_compare(1 + data_words(XFER_LENS[0]));
   endtask

   task automatic test_rounding();
      int i;
      for (i = 1; i < 4; i++) begin
         run_transfer(4'd2, XFER_LENS[i]);
         drain_and_compare(1 + data_words(XFER_LENS[i]));
      end
   endtask

   // Length word plus 512 data words, one more than the buffer holds
   task automatic test_overflow();
      int i;
      run_transfer(4'd9, XFER_LENS[4]);
      check_bit("overflow", overflow, 1'b1);
      check_bit("cpci_dma_q_nearly_full_c2n", cpci_dma_q_nearly_full_c2n, 1'b1);
      for (i = 0; i < 5 && overflow; i++) begin
         @(negedge nclk);
      end
      if (overflow) begin
         report_failure("overflow stayed high more than 5 cycles after the dropped word");
      end
      drain_and_compare(`DMA_RX_DEPTH);
   endtask

   // ======================================================================
   // Main sequence and watchdog
   // ======================================================================
   initial begin
      nclk                 = 1'b0;
      nreset               = 1'b1;
      dma_rd_request       = 1'b0;
      dma_rd_request_q     = '0;
      dma_rd_en            = 1'b0;
      cpci_dma_op_code_ack = OP_IDLE;
      cpci_dma_vld_n2c     = 1'b0;
      cpci_dma_data_n2c    = '0;
      ack_pipe[0]          = OP_IDLE;
      ack_pipe[1]          = OP_IDLE;
      status_exp           = '0;
      lcg_state            = 32'd2;
      fork
         echo_op_codes();
      join_none
      repeat (10) @(posedge nclk);
      nreset <= 1'b0;
      test_reset_values();
      test_status_query();
      test_transfer();
      test_rounding();
      test_overflow();
      $display("Everything OK");
      $finish;
   end

   initial begin
      repeat (expected_cycles() * 2 + 2000) @(posedge nclk);
      report_failure("Timeout: the tests did not finish in the expected number of cycles");
   end

endmodule

// File: verilog/dma_bus_master.sv
// ==========================================================================
// DMA bus master, network clock domain
// Status query loop and network-to-host packet transfer into the receive
// buffer over the chip-to-chip op-code handshake
// ==========================================================================
`timescale 1ns/1ps

module dma_bus_master (
   input  logic                    nclk,
   input  logic                    nreset,
   // Host side
   input  logic                    dma_rd_request,
   input  dma_word_pkg::queue_id_t dma_rd_request_q,
   output dma_word_pkg::rx_word_t  dma_rd_data,
   input  logic                    dma_rd_en,
   output logic                    dma_empty,
   output logic                    dma_nearly_empty,
   output logic                    dma_all_in_buf,
   output logic                    overflow,
   output dma_word_pkg::queue_vec_t dma_pkt_avail,
   output dma_word_pkg::queue_vec_t dma_can_wr_pkt,
   // Network side
   output dma_op_pkg::op_req_t     cpci_dma_op_req,
   input  dma_op_pkg::op_code_t    cpci_dma_op_code_ack,
   input  logic                    cpci_dma_vld_n2c,
   input  dma_word_pkg::n2c_word_t cpci_dma_data_n2c,
   output logic                    cpci_dma_q_nearly_full_c2n
);
   import dma_word_pkg::*;

   n2c_word_t   n2c_word;
   dma_status_t status;
   rx_word_t    rx_wr_data;
   logic        status_ld;
   logic        avail_clr;
   logic        len_ld;
   logic        word_inc;
   logic        xfer_start;
   logic        rx_wr;
   logic        all_in_buf;

   // Buffer stores the raw link word, length word included
   assign rx_wr_data = n2c_word;

   dma_op_sequencer seq0 (
      .nclk         (nclk),
      .nreset       (nreset),
      .rd_request   (dma_rd_request),
      .rd_request_q (dma_rd_request_q),
      .op_code_ack  (cpci_dma_op_code_ack),
      .vld_n2c      (cpci_dma_vld_n2c),
      .data_n2c     (cpci_dma_data_n2c),
      .all_in_buf   (all_in_buf),
      .op_req       (cpci_dma_op_req),
      .n2c_word     (n2c_word),
      .status_ld    (status_ld),
      .avail_clr    (avail_clr),
      .len_ld       (len_ld),
      .word_inc     (word_inc),
      .xfer_start   (xfer_start),
      .rx_wr        (rx_wr)
   );

   dma_status_regs status0 (
      .nclk      (nclk),
      .nreset    (nreset),
      .n2c_word  (n2c_word),
      .status_ld (status_ld),
      .avail_clr (avail_clr),
      .status    (status)
   );

   dma_word_counter cnt0 (
      .nclk       (nclk),
      .nreset     (nreset),
      .n2c_word   (n2c_word),
      .xfer_start (xfer_start),
      .len_ld     (len_ld),
      .word_inc   (word_inc),
      .all_in_buf (all_in_buf)
   );

   dma_rx_fifo rx_fifo0 (
      .nclk         (nclk),
      .nreset       (nreset),
      .wr           (rx_wr),
      .wr_data      (rx_wr_data),
      .rd_en        (dma_rd_en),
      .rd_data      (dma_rd_data),
      .empty        (dma_empty),
      .nearly_empty (dma_nearly_empty),
      .nearly_full  (cpci_dma_q_nearly_full_c2n),
      .overflow     (overflow)
   );

   // Split the status word into the two host vectors
   assign dma_pkt_avail  = status.pkt_avail;
   assign dma_can_wr_pkt = status.can_wr_pkt;
   assign dma_all_in_buf = all_in_buf;

endmodule

// File: verilog/dma_rx_fifo.sv
// ==========================================================================
// DMA receive buffer
// Single-clock first-word-fall-through FIFO with level flags,
// dropped-write detection and a stretched overflow flag
// ==========================================================================
`timescale 1ns/1ps
`include "dma_settings.svh"

module dma_rx_fifo (
   input  logic                   nclk,
   input  logic                   nreset,
   input  logic                   wr,
   input  dma_word_pkg::rx_word_t wr_data,
   input  logic                   rd_en,
   output dma_word_pkg::rx_word_t rd_data,
   output logic                   empty,
   output logic                   nearly_empty,
   output logic                   nearly_full,
   output logic                   overflow
);
   import dma_word_pkg::*;

   localparam int DEPTH  = `DMA_RX_DEPTH;
   localparam int ADDR_W = $clog2(DEPTH);
   localparam int LVL_W  = ADDR_W + 1;
   localparam int HOLD_W = $clog2(`DMA_OVERFLOW_HOLD + 1);

   rx_word_t          mem [DEPTH];
   logic [ADDR_W-1:0] wr_ptr;
   logic [ADDR_W-1:0] rd_ptr;
   logic [LVL_W-1:0]  level;
   logic              full;
   logic              do_wr;
   logic              do_rd;
   logic              drop;
   logic [HOLD_W-1:0] hold_cnt;

   assign full         = (level == LVL_W'(DEPTH));
   assign empty        = (level == '0);
   assign nearly_empty = (level <= LVL_W'(`DMA_RX_NEARLY_EMPTY_LEVEL));
   // No back-pressure on the link, a word into a full buffer is lost
   assign do_wr        = wr && !full;
   assign drop         = wr && full;
   assign do_rd        = rd_en && !empty;

   // Head word always visible
   assign rd_data = mem[rd_ptr];

   always_ff @(posedge nclk) begin
      if (do_wr) begin
         mem[wr_ptr] <= wr_data;
      end
   end

   // =======================================================================
   // Pointers and level
   // =======================================================================
   always_ff @(posedge nclk) begin
      if (nreset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         level  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + ADDR_W'(1);
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + ADDR_W'(1);
         end
         case ({do_wr, do_rd})
            2'b10:   level <= level + LVL_W'(1);
            2'b01:   level <= level - LVL_W'(1);
            default: level <= level;
         endcase
      end
   end

   // Nearly-full one register behind the level
   always_ff @(posedge nclk) begin
      if (nreset) begin
         nearly_full <= 1'b0;
      end else begin
         nearly_full <= (level >= LVL_W'(DEPTH - `DMA_RX_NEARLY_FULL_MARGIN));
      end
   end

   // =======================================================================
   // Overflow stretch
   // =======================================================================
   // Each drop reloads the hold count
   always_ff @(posedge nclk) begin
      if (nreset) begin
         overflow <= 1'b0;
         hold_cnt <= '0;
      end else if (drop) begin
         overflow <= 1'b1;
         hold_cnt <= HOLD_W'(`DMA_OVERFLOW_HOLD);
      end else if (hold_cnt == '0) begin
         overflow <= 1'b0;
      end else begin
         hold_cnt <= hold_cnt - HOLD_W'(1);
      end
   end

endmodule

// File: verilog/dma_word_counter.sv
// ==========================================================================
// DMA word counter
// Expected versus received data words of the packet in flight
// ==========================================================================
`timescale 1ns/1ps
`include "dma_settings.svh"

module dma_word_counter (
   input  logic                    nclk,
   input  logic                    nreset,
   input  dma_word_pkg::n2c_word_t n2c_word,
   input  logic                    xfer_start,
   input  logic                    len_ld,
   input  logic                    word_inc,
   output logic                    all_in_buf
);

   // Spare top bit so a 2047-byte packet (512 words) fits
   localparam int CNT_W = `DMA_WORD_CNT_W + 1;

   logic [CNT_W-1:0]           exp_words;
   logic [CNT_W-1:0]           rcv_words;
   logic [`DMA_WORD_CNT_W-1:0] len_words;
   logic                       len_part;

   // Whole words, plus one if the byte count has a remainder
   assign len_words = n2c_word.length.byte_len[`DMA_LEN_W-1:2];
   assign len_part  = |n2c_word.length.byte_len[1:0];

   always_ff @(posedge nclk) begin
      if (nreset || xfer_start) begin
         // Never matches until the length arrives
         exp_words <= '1;
         rcv_words <= '0;
      end else if (len_ld) begin
         exp_words <= {1'b0, len_words} + CNT_W'(len_part);
         rcv_words <= '0;
      end else if (word_inc) begin
         rcv_words <= rcv_words + CNT_W'(1);
      end
   end

   assign all_in_buf = (rcv_words == exp_words);

endmodule

// File: verilog/dma_status_regs.sv
// ==========================================================================
// DMA status registers
// Published packet-available and can-write vectors from the status query
// ==========================================================================
`timescale 1ns/1ps

module dma_status_regs (
   input  logic                      nclk,
   input  logic                      nreset,
   input  dma_word_pkg::n2c_word_t   n2c_word,
   input  logic                      status_ld,
   input  logic                      avail_clr,
   output dma_word_pkg::dma_status_t status
);

   // Load the whole status view, then apply the clear on top
   // Clear touches only the packet-available half
   always_ff @(posedge nclk) begin
      if (nreset) begin
         status <= '0;
      end else begin
         if (status_ld) begin
            status <= n2c_word.status;
         end
         // Queue being served must not look available to the host
         if (avail_clr) begin
            status.pkt_avail <= '0;
         end
      end
   end

endmodule

// File: verilog/dma_op_sequencer.sv
// ==========================================================================
// DMA op sequencer
// Flops the link inputs, holds a pending read request and runs the
// op-code handshake FSM for status queries and network-to-host transfers
// ==========================================================================
`timescale 1ns/1ps

module dma_op_sequencer (
   input  logic                    nclk,
   input  logic                    nreset,
   input  logic                    rd_request,
   input  dma_word_pkg::queue_id_t rd_request_q,
   input  dma_op_pkg::op_code_t    op_code_ack,
   input  logic                    vld_n2c,
   input  dma_word_pkg::n2c_word_t data_n2c,
   input  logic                    all_in_buf,
   output dma_op_pkg::op_req_t     op_req,
   output dma_word_pkg::n2c_word_t n2c_word,
   output logic                    status_ld,
   output logic                    avail_clr,
   output logic                    len_ld,
   output logic                    word_inc,
   output logic                    xfer_start,
   output logic                    rx_wr
);
   import dma_op_pkg::*;
   import dma_word_pkg::*;

   op_code_t   ack_d1;
   logic       vld_d1;
   n2c_word_t  word_d1;
   logic       rx_req;
   queue_id_t  rx_req_q;
   logic       req_clr;
   seq_state_t state;
   seq_state_t state_nxt;
   op_req_t    op_req_nxt;

   // =======================================================================
   // Input flops
   // =======================================================================
   always_ff @(posedge nclk) begin
      if (nreset) begin
         ack_d1 <= OP_IDLE;
         vld_d1 <= 1'b0;
      end else begin
         ack_d1 <= op_code_ack;
         vld_d1 <= vld_n2c;
      end
   end

   // Payload only, qualified by vld_d1
   always_ff @(posedge nclk) begin
      word_d1 <= data_n2c;
   end

   assign n2c_word = word_d1;

   // Pending read request
   // A new pulse wins over the clear so a request is never lost at ack
   always_ff @(posedge nclk) begin
      if (nreset) begin
         rx_req <= 1'b0;
      end else if (rd_request) begin
         rx_req <= 1'b1;
      end else if (req_clr) begin
         rx_req <= 1'b0;
      end
   end

   always_ff @(posedge nclk) begin
      if (rd_request) begin
         rx_req_q <= rd_request_q;
      end
   end

   // =======================================================================
   // Op-code FSM
   // =======================================================================
   always_comb begin
      state_nxt  = state;
      op_req_nxt = op_req;
      status_ld  = 1'b0;
      avail_clr  = 1'b0;
      len_ld     = 1'b0;
      word_inc   = 1'b0;
      xfer_start = 1'b0;
      rx_wr      = 1'b0;
      req_clr    = 1'b0;
      case (state)
         ST_QUERY_REQ: begin
            op_req_nxt.op_code = OP_STATUS_QUERY;
            if (ack_d1 == OP_STATUS_QUERY) begin
               state_nxt = ST_QUERY_ACK;
            end
         end
         ST_QUERY_ACK: begin
            // Status words keep updating the vectors until a request shows up
            status_ld = vld_d1;
            if (rx_req) begin
               // Mask the avail vector so the host does not ask again
               avail_clr           = 1'b1;
               xfer_start          = 1'b1;
               op_req_nxt.queue_id = rx_req_q;
               state_nxt           = ST_XFER_REQ;
            end
         end
         ST_XFER_REQ: begin
            op_req_nxt.op_code = OP_XFER_N2C;
            if (ack_d1 == OP_XFER_N2C) begin
               req_clr   = 1'b1;
               state_nxt = ST_XFER_LEN;
            end
         end
         ST_XFER_LEN: begin
            // Length word goes into the buffer ahead of the data
            if (vld_d1) begin
               len_ld    = 1'b1;
               rx_wr     = 1'b1;
               state_nxt = ST_XFER_DATA;
            end
         end
         ST_XFER_DATA: begin
            if (vld_d1 && !all_in_buf) begin
               rx_wr    = 1'b1;
               word_inc = 1'b1;
            end
            if (all_in_buf) begin
               state_nxt = ST_QUERY_REQ;
            end
         end
         default: begin
            state_nxt = ST_QUERY_REQ;
         end
      endcase
   end

   always_ff @(posedge nclk) begin
      if (nreset) begin
         state  <= ST_QUERY_REQ;
         op_req <= '{op_code: OP_STATUS_QUERY, queue_id: '0};
      end else begin
         state  <= state_nxt;
         op_req <= op_req_nxt;
      end
   end

endmodule

// File: verilog/dma_word_pkg.sv
// ==========================================================================
// DMA word package
// Queue vectors, status layout and the two views of an incoming link word
// ==========================================================================
`include "dma_settings.svh"

package dma_word_pkg;

   // One bit per queue
   typedef logic [`DMA_NUM_QUEUES-1:0] queue_vec_t;
   typedef logic [`DMA_QUEUE_ID_W-1:0] queue_id_t;

   // Status answer, packet-available in the upper half
   typedef struct packed {
      queue_vec_t pkt_avail;
      queue_vec_t can_wr_pkt;
   } dma_status_t;

   // Length word, byte count in the low bits
   typedef struct packed {
      logic [`DMA_DATA_W-`DMA_LEN_W-1:0] rsvd;
      logic [`DMA_LEN_W-1:0]             byte_len;
   } n2c_len_t;

   // Network-to-host word
   // Status view in the query state, length view at transfer start
   typedef union packed {
      dma_status_t status;
      n2c_len_t    length;
   } n2c_word_t;

   // Word as stored in the receive buffer
   typedef logic [`DMA_DATA_W-1:0] rx_word_t;

endpackage

// File: verilog/dma_op_pkg.sv
// ==========================================================================
// DMA op package
// Link op codes, sequencer states and the op request sent to the network
// ==========================================================================
`include "dma_settings.svh"

package dma_op_pkg;

   // Op codes on the request/acknowledge handshake
   typedef enum logic [1:0] {
      OP_IDLE         = 2'b00,
      OP_STATUS_QUERY = 2'b01,
      OP_XFER_C2N     = 2'b10,
      OP_XFER_N2C     = 2'b11
   } op_code_t;

   // Sequencer states, network-to-host path only
   typedef enum logic [2:0] {
      ST_QUERY_REQ = 3'h0,
      ST_QUERY_ACK = 3'h1,
      ST_XFER_REQ  = 3'h2,
      ST_XFER_LEN  = 3'h3,
      ST_XFER_DATA = 3'h4
   } seq_state_t;

   // Op code plus the queue it refers to
   typedef struct packed {
      op_code_t                    op_code;
      logic [`DMA_QUEUE_ID_W-1:0]  queue_id;
   } op_req_t;

endpackage

// File: verilog/dma_settings.svh
// ==========================================================================
// DMA bus master settings
// Link widths, receive buffer sizing and flag thresholds
// ==========================================================================
`ifndef DMA_SETTINGS_SVH
`define DMA_SETTINGS_SVH

// Link and queue sizing
`define DMA_DATA_W                32
`define DMA_NUM_QUEUES            16
`define DMA_QUEUE_ID_W            4

// Receive buffer
`define DMA_RX_DEPTH              512
`define DMA_RX_NEARLY_FULL_MARGIN 16
`define DMA_RX_NEARLY_EMPTY_LEVEL 3
`define DMA_OVERFLOW_HOLD         3

// Packet length fields
`define DMA_LEN_W                 11
`define DMA_WORD_CNT_W            9

`endif
